//--- design/obi_attr_pkg.sv
/* Widths, memory geometry and wait-state rule shared by the OBI segment.
   Word index is address bits 7:2; only the first MEM_WORDS indices are backed by storage. */
`default_nettype none

package obi_attr_pkg;

  // Bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Word index taken from the byte address, byte offset dropped
  localparam int WIDX_W = ADDR_W - 2;

  // Memory geometry and the slow region at the top of it
  localparam int MEM_WORDS = 16;
  localparam int MEM_AW    = $clog2(MEM_WORDS);
  localparam int SLOW_FROM = 8;
  localparam int SLOW_WAIT = 2;
  localparam int WAIT_W    = $clog2(SLOW_WAIT + 1);

  // Outstanding limit, also the depth of the tracker and the target queue
  localparam int MAX_OUTST = 2;
  localparam int CNT_W     = $clog2(MAX_OUTST + 1);

  // OBI protection attribute
  typedef logic [2:0] prot_t;

  // True when the word index falls inside the backed memory
  function automatic logic word_in_range(logic [WIDX_W-1:0] widx);
    return widx < WIDX_W'(MEM_WORDS);
  endfunction

  // Extra cycles a request spends at the head of the target queue
  // Out-of-range words answer at once, like the fast region
  function automatic logic [WAIT_W-1:0] wait_states(logic [WIDX_W-1:0] widx);
    if (word_in_range(widx) && widx >= WIDX_W'(SLOW_FROM)) begin
      return WAIT_W'(SLOW_WAIT);
    end
    return '0;
  endfunction

endpackage

`default_nettype wire

//--- design/obi_if.sv
/* OBI request/grant plus rvalid, with prot as the only optional signal.
   No byte enables and no rready, so responses cannot be stalled. */
`default_nettype none

interface obi_if
  import obi_attr_pkg::*;
  ();

  // Request channel
  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] addr;
  logic              we;
  logic [DATA_W-1:0] wdata;
  prot_t             prot;

  // Response channel, one beat per rvalid cycle, in request order
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport initiator (
    output req, addr, we, wdata, prot,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, addr, we, wdata, prot,
    output gnt, rvalid, rdata, err
  );

  // Passive view for trackers and checkers
  modport monitor (
    input req, gnt, addr, we, wdata, prot, rvalid, rdata, err
  );

endinterface

`default_nettype wire

//--- design/obi_initiator.sv
/* Holds a single command until granted and caps outstanding requests at MAX_OUTST.
   cmd_ready depends combinationally on gnt and rvalid of the same cycle. */
`default_nettype none

module obi_initiator
  import obi_attr_pkg::*;
  (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic              cmd_we,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  prot_t             cmd_prot,
    output logic              rsp_valid,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_err,
    obi_if.initiator          bus
  );

  logic              hold_valid_q;
  logic [ADDR_W-1:0] hold_addr_q;
  logic              hold_we_q;
  logic [DATA_W-1:0] hold_wdata_q;
  prot_t             hold_prot_q;
  logic [CNT_W-1:0]  outst_q;
  logic [CNT_W-1:0]  outst_d;
  logic              grant;
  logic              cmd_accept;

  // The held command is the request, so req rises on the accepting edge
  assign bus.req   = hold_valid_q;
  assign bus.addr  = hold_addr_q;
  assign bus.we    = hold_we_q;
  assign bus.wdata = hold_wdata_q;
  assign bus.prot  = hold_prot_q;

  assign grant = bus.req && bus.gnt;

  // Granted but not yet answered, after this cycle's grant and response
  assign outst_d = outst_q + CNT_W'(grant) - CNT_W'(bus.rvalid);

  // Accept into an empty or emptying register, and only while a grant of
  // the new command could not push the count past the limit
  assign cmd_ready  = (!hold_valid_q || grant) && (outst_d < CNT_W'(MAX_OUTST));
  assign cmd_accept = cmd_valid && cmd_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
      outst_q      <= '0;
    end else begin
      outst_q <= outst_d;
      if (cmd_accept) begin
        hold_valid_q <= 1'b1;
      end else if (grant) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  // Payload only matters while hold_valid_q is set
  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      hold_addr_q  <= cmd_addr;
      hold_we_q    <= cmd_we;
      hold_wdata_q <= cmd_wdata;
      hold_prot_q  <= cmd_prot;
    end
  end

  // Responses pass straight through, the target already zeroes rdata
  assign rsp_valid = bus.rvalid;
  assign rsp_rdata = bus.rdata;
  assign rsp_err   = bus.err;

  a_outst_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outst_q <= CNT_W'(MAX_OUTST));

  // OBI: a pending request may not change or drop before its grant
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.req && !bus.gnt |=> bus.req && $stable({bus.addr, bus.we, bus.wdata, bus.prot}));

endmodule

`default_nettype wire

//--- design/obi_attr_fifo.sv
/* Pairs each rvalid with the prot of the request it answers, for up to MAX_OUTST in flight.
   Relies on in-order responses; rsp_prot is zero outside rvalid cycles. */
`default_nettype none

module obi_attr_fifo
  import obi_attr_pkg::*;
  (
    input  logic   clk_i,
    input  logic   rst_ni,
    output prot_t  rsp_prot,
    obi_if.monitor mon
  );

  // Entry 0 is the oldest granted request
  prot_t            store_q [MAX_OUTST];
  prot_t            store_d [MAX_OUTST];
  logic [CNT_W-1:0] fill_q;
  logic [CNT_W-1:0] fill_d;
  logic             grant;

  assign grant = mon.req && mon.gnt;

  // A response retires the oldest entry before a grant in the same cycle
  // writes behind whatever is left
  always_comb begin
    store_d = store_q;
    fill_d  = fill_q;
    if (mon.rvalid) begin
      for (int i = 0; i < MAX_OUTST - 1; i++) begin
        store_d[i] = store_q[i+1];
      end
      fill_d = fill_d - 1'b1;
    end
    if (grant) begin
      for (int i = 0; i < MAX_OUTST; i++) begin
        if (CNT_W'(i) == fill_d) begin
          store_d[i] = mon.prot;
        end
      end
      fill_d = fill_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  always_ff @(posedge clk_i) begin
    store_q <= store_d;
  end

  // Read in the response cycle itself
  assign rsp_prot = mon.rvalid ? store_q[0] : '0;

  // The target's queue and the initiator's limit must keep the tracker in range
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(grant && fill_q == CNT_W'(MAX_OUTST) && !mon.rvalid));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mon.rvalid |-> fill_q != '0);

endmodule

`default_nettype wire

//--- design/obi_mem_target.sv
/* 16-word OBI memory with a MAX_OUTST-slot request queue; memory clears on reset.
   Slow-region words hold the head for SLOW_WAIT extra cycles; out-of-range words answer err. */
`default_nettype none

module obi_mem_target
  import obi_attr_pkg::*;
  (
    input  logic  clk_i,
    input  logic  rst_ni,
    obi_if.target bus
  );

  typedef struct packed {
    logic [WIDX_W-1:0] widx;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } slot_t;

  slot_t             queue_q [MAX_OUTST];
  slot_t             queue_d [MAX_OUTST];
  slot_t             head;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_d;
  logic [WAIT_W-1:0] wait_q;
  logic [WAIT_W-1:0] wait_d;
  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic              head_ok;
  logic              push;
  logic              pop;

  assign head    = queue_q[0];
  assign head_ok = word_in_range(head.widx);

  // Head answers once its wait counter has run out
  assign pop = (cnt_q != '0) && (wait_q == '0);

  // Grant only against a pending request, and only with room in the queue
  // A slot retiring this cycle counts as room
  assign bus.gnt = bus.req && ((cnt_q != CNT_W'(MAX_OUTST)) || pop);
  assign push    = bus.req && bus.gnt;

  assign bus.rvalid = pop;
  assign bus.err    = pop && !head_ok;
  // Writes and errors return zero data
  assign bus.rdata  = (pop && head_ok && !head.we) ? mem_q[head.widx[MEM_AW-1:0]] : '0;

  always_comb begin
    queue_d = queue_q;
    cnt_d   = cnt_q;
    wait_d  = wait_q;
    if (pop) begin
      for (int i = 0; i < MAX_OUTST - 1; i++) begin
        queue_d[i] = queue_q[i+1];
      end
      cnt_d = cnt_d - 1'b1;
    end
    if (push) begin
      for (int i = 0; i < MAX_OUTST; i++) begin
        if (CNT_W'(i) == cnt_d) begin
          queue_d[i] = '{widx: bus.addr[ADDR_W-1:2], we: bus.we, wdata: bus.wdata};
        end
      end
      cnt_d = cnt_d + 1'b1;
    end
    // A new head arrives when the old one retires or the queue was empty,
    // and it starts with the wait count of its own region
    if ((pop || cnt_q == '0) && cnt_d != '0) begin
      wait_d = wait_states(queue_d[0].widx);
    end else if (wait_q != '0) begin
      wait_d = wait_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      wait_q <= '0;
      mem_q  <= '{default: '0};
    end else begin
      cnt_q  <= cnt_d;
      wait_q <= wait_d;
      // Out-of-range writes are dropped
      if (pop && head.we && head_ok) begin
        mem_q[head.widx[MEM_AW-1:0]] <= head.wdata;
      end
    end
  end

  // Payload of the queue slots, shifted on pop and filled behind the last valid slot
  always_ff @(posedge clk_i) begin
    queue_q <= queue_d;
  end

  // A slow-region grant into an empty queue takes exactly SLOW_WAIT extra cycles
  a_slow_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push && cnt_q == '0 && wait_states(bus.addr[ADDR_W-1:2]) != '0
      |=> !bus.rvalid [*SLOW_WAIT] ##1 bus.rvalid);

endmodule

`default_nettype wire

//--- design/obi_attr_top.sv
/* OBI segment: command front end, attribute tracker and memory target on one bus.
   At most MAX_OUTST commands are in flight; responses return in command order. */
`default_nettype none

module obi_attr_top
  import obi_attr_pkg::*;
  (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Command port, valid/ready
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic              cmd_we,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  prot_t             cmd_prot,
    // Response port, one pulse per command
    output logic              rsp_valid,
    output logic [DATA_W-1:0] rsp_rdata,
    output logic              rsp_err,
    output prot_t             rsp_prot
  );

  obi_if bus_if ();

  obi_initiator u_initiator (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_addr  (cmd_addr),
    .cmd_we    (cmd_we),
    .cmd_wdata (cmd_wdata),
    .cmd_prot  (cmd_prot),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err),
    .bus       (bus_if.initiator)
  );

  // Tracker watches the same bus and supplies prot in the rvalid cycle
  obi_attr_fifo u_attr_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rsp_prot (rsp_prot),
    .mon      (bus_if.monitor)
  );

  obi_mem_target u_target (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (bus_if.target)
  );

endmodule

`default_nettype wire

//--- tests/obi_attr_tb.sv
/* Random OBI command traffic from a fixed LFSR seed, checked against an in-order model.
   Expected responses are fixed when a command is accepted, since replies come in order. */
`default_nettype none

module obi_attr_tb
  import obi_attr_pkg::*;
  ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'haca9ae09;
  localparam int LONG_RUN_CMDS = 200;
  localparam int ACCEPT_TO = 50;
  localparam int DRAIN_TO = 100;

  logic clk_i = 1'b0;
  logic rst_ni, cmd_valid, cmd_ready, cmd_we, rsp_valid, rsp_err;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_wdata, rsp_rdata;
  prot_t cmd_prot, rsp_prot;

  // Reference model memory plus the expected responses in command order
  logic [DATA_W-1:0] model_mem [MEM_WORDS];
  logic [DATA_W-1:0] exp_rdata [$];
  logic exp_err [$];
  prot_t exp_prot [$];
  logic [5:0] mon_widx;
  logic mon_ok;
  logic [DATA_W-1:0] got_rdata;
  logic got_err;
  prot_t got_prot;

  logic [31:0] lfsr_q = SEED;
  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int acc_cnt = 0;
  int rsp_cnt = 0;

  obi_attr_top u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_addr(cmd_addr),
    .cmd_we(cmd_we), .cmd_wdata(cmd_wdata), .cmd_prot(cmd_prot),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err), .rsp_prot(rsp_prot)
  );

  always #4 clk_i = ~clk_i;

  // Right-shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit and each new bit shifted in at the low end of v
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %0s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report();
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("Timeout: %0s", what);
    err_cnt++;
    fail_cnt++;
    report();
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %0s: fail with %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  // Called on a rising edge; returns on the edge where the command is taken
  task automatic send_cmd(input logic [5:0] widx, input logic we);
    logic [31:0] d;
    logic [31:0] p;
    int t;
    draw(32, d);
    draw(3, p);
    cmd_valid <= 1'b1;
    cmd_addr  <= {widx, 2'b00};
    cmd_we    <= we;
    cmd_wdata <= d;
    cmd_prot  <= p[2:0];
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!cmd_ready && t < ACCEPT_TO);
    if (!cmd_ready) give_up($sformatf("command %0d was never accepted", acc_cnt));
  endtask

  task automatic idle(input int n);
    cmd_valid <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // Waits until every accepted command has had its response
  // The model queue is read on the falling edge, after the monitor has updated it
  task automatic drain(input string name);
    int t;
    cmd_valid <= 1'b0;
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (exp_prot.size() != 0 && t < DRAIN_TO);
    if (exp_prot.size() != 0) begin
      give_up($sformatf("the response to command %0d never came in %0s", rsp_cnt, name));
    end else begin
      @(posedge clk_i);
    end
  endtask

  // Model update on each accepted command and compare on each response
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cmd_valid && cmd_ready) begin
        mon_widx = cmd_addr[7:2];
        mon_ok = mon_widx < 6'(MEM_WORDS);
        exp_rdata.push_back((!cmd_we && mon_ok) ? model_mem[mon_widx[3:0]] : '0);
        exp_err.push_back(!mon_ok);
        exp_prot.push_back(cmd_prot);
        if (cmd_we && mon_ok) model_mem[mon_widx[3:0]] = cmd_wdata;
        acc_cnt++;
      end
      if (rsp_valid) begin
        rsp_cnt++;
        if (exp_prot.size() == 0) begin
          $display("A response arrived with no command waiting for one");
          err_cnt++;
        end else begin
          got_rdata = exp_rdata.pop_front();
          got_err = exp_err.pop_front();
          got_prot = exp_prot.pop_front();
          check("rsp_rdata", rsp_rdata, got_rdata);
          check("rsp_err", 32'(rsp_err), 32'(got_err));
          check("rsp_prot", 32'(rsp_prot), 32'(got_prot));
        end
      end
      if (acc_cnt - rsp_cnt > MAX_OUTST) begin
        $display("More than %0d commands were in flight at once", MAX_OUTST);
        err_cnt++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    int e;
    foreach (model_mem[i]) model_mem[i] = '0;
    rst_ni = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_we = 1'b0;
    cmd_wdata = '0;
    cmd_prot = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    e = err_cnt;
    check("cmd_ready", 32'(cmd_ready), 32'd1);
    check("rsp_valid", 32'(rsp_valid), 32'd0);
    end_test("reset_state", e);

    // Fill every word, then read each one back
    e = err_cnt;
    for (int i = 0; i < MEM_WORDS; i++) send_cmd(6'(i), 1'b1);
    for (int i = 0; i < MEM_WORDS; i++) send_cmd(6'(i), 1'b0);
    drain("write_read");
    end_test("write_read", e);

    // Index 16 to 63 must answer err and leave the words intact
    e = err_cnt;
    for (int i = 0; i < 12; i++) begin
      draw(6, r);
      draw(1, w);
      send_cmd(6'(MEM_WORDS) + 6'(r[5:0] % 6'd48), w[0]);
    end
    for (int i = 0; i < MEM_WORDS; i++) send_cmd(6'(i), 1'b0);
    drain("out_of_range");
    end_test("out_of_range", e);

    // Slow and fast words alternate so latencies differ between neighbours
    e = err_cnt;
    for (int i = 0; i < 24; i++) begin
      draw(3, r);
      draw(1, w);
      send_cmd((i % 2 == 0) ? 6'(SLOW_FROM) + 6'(r[2:0]) : 6'(r[2:0]), w[0]);
    end
    drain("prot_pairing");
    end_test("prot_pairing", e);

    // cmd_valid stays high throughout; the monitor counts what is in flight
    e = err_cnt;
    for (int i = 0; i < 32; i++) begin
      draw(6, r);
      draw(1, w);
      send_cmd(r[5:0], w[0]);
    end
    drain("outstanding_limit");
    end_test("outstanding_limit", e);

    e = err_cnt;
    for (int i = 0; i < LONG_RUN_CMDS; i++) begin
      draw(5, r);
      draw(1, w);
      send_cmd(6'(r[4:0]), w[0]);
      draw(2, r);
      if (r[1:0] != 2'd0) idle(int'(r[1:0]));
    end
    drain("long_run");
    idle(4);
    check("response_count", 32'(rsp_cnt), 32'(acc_cnt));
    end_test("long_run", e);

    report();
  end

endmodule

`default_nettype wire

//--- obi_attr_top.f
design/obi_attr_pkg.sv
design/obi_if.sv
design/obi_initiator.sv
design/obi_attr_fifo.sv
design/obi_mem_target.sv
design/obi_attr_top.sv
tests/obi_attr_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f obi_attr_top.f \
  --top-module obi_attr_tb -o obi_attr_sim || exit 1
out="$(./obj_dir/obi_attr_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'all tests passed' && echo "PASS" || { echo "FAIL"; exit 1; }
